//--- flist.f
+incdir+hdl
+incdir+verif
hdl/lane_init_pkg.sv
hdl/link_state_fsm.sv
hdl/cld_param_collect.sv
hdl/os_training_counter.sv
hdl/sb_transaction_ctrl.sv
hdl/lane_init_top.sv
verif/tb_lane_init.sv

//--- Bender.yml
package:
  name: lane_init

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/lane_init_pkg.sv
      - hdl/link_state_fsm.sv
      - hdl/cld_param_collect.sv
      - hdl/os_training_counter.sv
      - hdl/sb_transaction_ctrl.sv
      - hdl/lane_init_top.sv
  - target: test
    include_dirs:
      - hdl
      - verif
    files:
      - verif/tb_lane_init.sv

//--- verif/tb_lane_init_model.svh
`ifndef TB_LANE_INIT_MODEL_SVH
`define TB_LANE_INIT_MODEL_SVH

// Link speed is the lower of the cable and partner generations
function automatic gen_speed_e expected_speed(input logic [31:0] cable,
                                              input logic [23:0] payload);
    int cable_gen;
    int partner_gen;
    int link_gen;
    cable_gen   = cable[`CABLE_GEN4_BIT] ? 4 : (cable[`CABLE_GEN3_BIT] ? 3 : 2);
    partner_gen = payload[`ADP_GEN4_BIT] ? 4 : (payload[`ADP_GEN3_BIT] ? 3 : 2);
    link_gen    = (cable_gen < partner_gen) ? cable_gen : partner_gen;
    case (link_gen)
        4:       return GEN4;
        3:       return GEN3;
        default: return GEN2;
    endcase
endfunction

// Lane-data select expected at each training step, step 4 is CL0
function automatic os_sel_e dsel_step(input gen_speed_e gen, input int idx);
    case (idx)
        0:       return (gen == GEN4) ? TS1_G4 : SLOS1;
        1:       return (gen == GEN4) ? TS2_G4 : SLOS2;
        2:       return (gen == GEN4) ? TS3_G4 : TS1_G3;
        3:       return (gen == GEN4) ? TS4_G4 : TS2_G3;
        default: return LANE_DATA;
    endcase
endfunction

// Ordered sets to transmit before a step may end
function automatic int sent_target(input gen_speed_e gen, input int idx);
    if (gen == GEN4) begin
        return `GEN4_TS_SENT;
    end
    case (idx)
        0, 1:    return `SLOS_SENT;
        2:       return (gen == GEN2) ? `GEN2_TS1_SENT : `GEN3_TS1_SENT;
        default: return (gen == GEN2) ? `GEN2_TS2_SENT : `GEN3_TS2_SENT;
    endcase
endfunction

// Matching ordered sets needed on each lane
function automatic int rcv_target(input gen_speed_e gen, input int idx);
    if (gen == GEN4) begin
        return `GEN4_TS_RCV;
    end
    return (idx < 2) ? `SLOS_RCV : `GEN3_TS_RCV;
endfunction

`endif

//--- verif/tb_lane_init.sv
`include "lane_init_macros.svh"

module tb_lane_init;
    timeunit 1ns;
    timeprecision 1ps;

    import lane_init_pkg::*;

    `include "tb_lane_init_model.svh"

    localparam int CLK_PERIOD      = 40;
    localparam int NUM_TESTS       = 7;
    localparam int CYCLES_PER_TEST = 2000;

    logic          fsm_clk;
    logic          reset_n;
    logic          sync_busy_i;
    lane_os_t      lane_os_i;
    logic          trans_error_i;
    logic          t_valid_i;
    logic          os_sent_i;
    logic [31:0]   c_data_i;
    logic          disconnect_sbrx_i;
    logic [23:0]   payload_i;
    logic          lane_disable_i;
    logic          tdisabled_min_i;
    train_timers_t timers_i;
    logic          trans_sent_i;
    logic          new_sym_i;
    os_sel_e       d_sel_o;
    trans_sel_e    trans_sel_o;
    gen_speed_e    gen_speed_o;
    logic [7:0]    c_address_o;
    logic          c_read_o;
    logic          disconnect_sbtx_o;
    logic          fsm_disabled_o;
    logic          fsm_training_o;
    logic          ts1_gen4_s_o;
    logic          ts2_gen4_s_o;

    int            seed;
    logic          track_dsel;
    os_sel_e       exp_dsel[$];

    lane_init_top lane_init_top_i (.*);

    always #(CLK_PERIOD / 2) fsm_clk = ~fsm_clk;

    task automatic check(input logic [31:0] actual, input logic [31:0] expected,
                         input string what);
        if (actual !== expected) begin
            $display("FAIL at %0t ns: %s, expected %0d, got %0d", $time, what, expected, actual);
            $display("SOME TESTS FAILED");
            $fatal(1, "stopped at the first mismatch");
        end
    endtask

    // Every step of the lane-data select is compared as it happens
    always @(d_sel_o) begin
        if (track_dsel) begin
            check(exp_dsel.size() > 0, 1'b1, "d_sel_o changed with no step pending");
            check(d_sel_o, exp_dsel.pop_front(), "d_sel_o training sequence");
        end
    end

    task automatic next_cycle();
        @(posedge fsm_clk);
        #2;
    endtask

    task automatic idle(input int cycles);
        repeat (cycles) next_cycle();
    endtask

    task automatic random_idle();
        idle($unsigned($random(seed)) % 4);
    endtask

    task automatic go_disabled();
        lane_disable_i = 1'b1;
        next_cycle();
        lane_disable_i = 1'b0;
        while (!fsm_disabled_o) begin
            next_cycle();
        end
    endtask

    // Leaves the DUT in CLD_EXCHANGE_1, where the sideband transmitter turns on
    task automatic bring_up(input logic [31:0] cable, input logic [23:0] payload);
        sync_busy_i     = 1'b1;
        c_data_i        = cable;
        payload_i       = payload;
        tdisabled_min_i = 1'b1;
        while (disconnect_sbtx_o) begin
            next_cycle();
        end
        tdisabled_min_i = 1'b0;
    endtask

    task automatic run_exchange(input logic [31:0] cable, input logic [23:0] payload);
        repeat (4) begin
            next_cycle();
            check(trans_sel_o, TR_NONE, "AT request while sync_busy_i is high");
        end
        sync_busy_i = 1'b0;
        while (trans_sel_o != TR_AT_CMD) begin
            next_cycle();
        end
        while (trans_sel_o == TR_AT_CMD) begin
            next_cycle();
        end
        // A transaction error asks for the AT request again
        t_valid_i     = 1'b1;
        trans_error_i = 1'b1;
        next_cycle();
        t_valid_i     = 1'b0;
        trans_error_i = 1'b0;
        check(trans_sel_o, TR_AT_CMD, "AT request repeated after trans_error_i");
        while (trans_sel_o == TR_AT_CMD) begin
            next_cycle();
        end
        check(gen_speed_o, expected_speed(cable, payload), "negotiated gen_speed_o");
        t_valid_i = 1'b1;
        next_cycle();
        t_valid_i = 1'b0;
    endtask

    task automatic enter_training(input logic [31:0] cable, input logic [23:0] payload);
        go_disabled();
        bring_up(cable, payload);
        run_exchange(cable, payload);
        trans_sent_i = 1'b1;
        next_cycle();
        trans_sent_i = 1'b0;
        new_sym_i    = 1'b1;
        next_cycle();
        new_sym_i    = 1'b0;
    endtask

    // Matching ordered sets on both lanes with a hold check before the last one
    task automatic receive_os(input os_sel_e code, input int count);
        for (int i = 0; i < count; i++) begin
            if (i == count - 1) begin
                idle(3);
            end else begin
                random_idle();
            end
            check(d_sel_o, code, "training step held until its receive target is met");
            lane_os_i.l0 = code;
            lane_os_i.l1 = code;
            next_cycle();
            lane_os_i.l0 = ZEROS;
            lane_os_i.l1 = ZEROS;
        end
    endtask

    // Sent pulses with a hold check before the last one and before the probe
    task automatic send_os(input os_sel_e code, input int count, input int probe);
        for (int i = 0; i < count; i++) begin
            if (i == count - 1 || i == probe) begin
                idle(3);
            end else begin
                random_idle();
            end
            check(d_sel_o, code, "training step held until its targets are met");
            os_sent_i = 1'b1;
            next_cycle();
            os_sent_i = 1'b0;
        end
    endtask

    task automatic train_step(input gen_speed_e gen, input int idx);
        os_sel_e code;
        int      n_sent;
        int      n_rcv;
        int      probe;
        code   = dsel_step(gen, idx);
        n_sent = sent_target(gen, idx);
        n_rcv  = rcv_target(gen, idx);
        // Gen2 TS1 must not end at the Gen3 count
        probe  = (gen == GEN2 && idx == 2) ? `GEN3_TS1_SENT : -1;
        while (d_sel_o != code) begin
            next_cycle();
        end
        check(fsm_training_o, 1'b1, "fsm_training_o during training");
        if (gen == GEN4) begin
            check(ts1_gen4_s_o, 1'b1, "ts1_gen4_s_o in Gen4 training");
            check(ts2_gen4_s_o, idx >= 1, "ts2_gen4_s_o in Gen4 training");
        end
        // Second step meets its sent target first so only the receive target holds it
        if (idx == 1) begin
            send_os(code, n_sent, probe);
            receive_os(code, n_rcv);
        end else begin
            receive_os(code, n_rcv);
            send_os(code, n_sent, probe);
        end
        // Last step also waits for a symbol boundary
        if (idx == 3) begin
            idle(3);
            check(d_sel_o, code, "last training step held until new_sym_i");
            new_sym_i = 1'b1;
        end
        while (d_sel_o == code) begin
            next_cycle();
        end
        new_sym_i = 1'b0;
    endtask

    task automatic run_training(input logic [31:0] cable, input logic [23:0] payload);
        gen_speed_e gen;
        gen = expected_speed(cable, payload);
        enter_training(cable, payload);
        exp_dsel.delete();
        for (int i = 0; i < 5; i++) begin
            exp_dsel.push_back(dsel_step(gen, i));
        end
        track_dsel = 1'b1;
        for (int idx = 0; idx < 4; idx++) begin
            train_step(gen, idx);
        end
        next_cycle();
        check(fsm_training_o, 1'b0, "fsm_training_o in CL0");
        check(exp_dsel.size(), 0, "d_sel_o steps left unseen");
        track_dsel = 1'b0;
    endtask

    task automatic test_cable_detect();
        int reads;
        reads           = 0;
        c_data_i        = 32'h0030_0012;
        tdisabled_min_i = 1'b1;
        repeat (8) begin
            next_cycle();
            check(disconnect_sbtx_o, 1'b1, "disconnect_sbtx_o with a non-USB4 cable");
            if (c_read_o) begin
                reads++;
                check(c_address_o, `CABLE_REG_ADDR, "c_address_o during the cable read");
            end
        end
        check(reads, 1, "c_read_o pulses in one cable visit");
        tdisabled_min_i = 1'b0;
        c_data_i        = 32'h0030_0040;
        while (disconnect_sbtx_o) begin
            next_cycle();
        end
    endtask

    // Starts in CL0 as the last training run leaves it
    task automatic test_fallbacks();
        check(d_sel_o, LANE_DATA, "d_sel_o in CL0 before lane disable");
        lane_disable_i = 1'b1;
        next_cycle();
        lane_disable_i = 1'b0;
        next_cycle();
        check(fsm_disabled_o, 1'b1, "fsm_disabled_o after lane_disable_i in CL0");
        enter_training(32'h0020_0040, 24'h04_0000);
        while (d_sel_o != TS1_G4) begin
            next_cycle();
        end
        repeat (4) begin
            os_sent_i = 1'b1;
            next_cycle();
            os_sent_i = 1'b0;
        end
        disconnect_sbrx_i = 1'b1;
        while (d_sel_o != ZEROS) begin
            next_cycle();
        end
        check(fsm_training_o, 1'b0, "fsm_training_o after sideband disconnect");
        disconnect_sbrx_i = 1'b0;
    endtask

    initial begin
        logic [31:0] cable;
        logic [23:0] payload;
        seed              = 32'h1802;
        fsm_clk           = 1'b0;
        reset_n           = 1'b0;
        sync_busy_i       = 1'b0;
        lane_os_i.l0      = ZEROS;
        lane_os_i.l1      = ZEROS;
        trans_error_i     = 1'b0;
        t_valid_i         = 1'b0;
        os_sent_i         = 1'b0;
        c_data_i          = '0;
        disconnect_sbrx_i = 1'b0;
        payload_i         = '0;
        lane_disable_i    = 1'b0;
        tdisabled_min_i   = 1'b0;
        timers_i          = '0;
        trans_sent_i      = 1'b0;
        new_sym_i         = 1'b0;
        track_dsel        = 1'b0;
        repeat (3) @(posedge fsm_clk);
        #2;
        reset_n = 1'b1;

        check(fsm_disabled_o, 1'b1, "fsm_disabled_o after reset");
        check(disconnect_sbtx_o, 1'b1, "disconnect_sbtx_o after reset");
        check(d_sel_o, ZEROS, "d_sel_o after reset");
        check(c_read_o, 1'b0, "c_read_o after reset");
        check(fsm_training_o, 1'b0, "fsm_training_o after reset");
        check(ts1_gen4_s_o, 1'b0, "ts1_gen4_s_o after reset");
        check(ts2_gen4_s_o, 1'b0, "ts2_gen4_s_o after reset");
        check(trans_sel_o, TR_NONE, "trans_sel_o after reset");

        test_cable_detect();

        // Random generation bits on both sides of a USB4 cable
        repeat (6) begin
            cable   = ($random(seed) & 32'hFFFF_FF00) | 32'h0000_0040;
            payload = 24'($random(seed));
            go_disabled();
            bring_up(cable, payload);
            run_exchange(cable, payload);
        end

        run_training(32'h0020_0040, 24'h04_0000);
        run_training(32'h0010_0040, 24'h04_0000);
        run_training(32'h0000_0040, 24'h04_2000);
        test_fallbacks();

        $display("ALL TESTS PASSED");
        $finish;
    end

    initial begin
        #(NUM_TESTS * CYCLES_PER_TEST * CLK_PERIOD);
        $display("Timeout: the run did not finish within %0d clock cycles",
                 NUM_TESTS * CYCLES_PER_TEST);
        $display("SOME TESTS FAILED");
        $fatal(1, "watchdog expired");
    end

endmodule

//--- hdl/lane_init_top.sv
module lane_init_top (
    input  logic                         fsm_clk,
    input  logic                         reset_n,
    input  logic                         sync_busy_i,
    input  lane_init_pkg::lane_os_t      lane_os_i,
    input  logic                         trans_error_i,
    input  logic                         t_valid_i,
    input  logic                         os_sent_i,
    input  logic [31:0]                  c_data_i,
    input  logic                         disconnect_sbrx_i,
    input  logic [23:0]                  payload_i,
    input  logic                         lane_disable_i,
    input  logic                         tdisabled_min_i,
    input  lane_init_pkg::train_timers_t timers_i,
    input  logic                         trans_sent_i,
    input  logic                         new_sym_i,
    output lane_init_pkg::os_sel_e       d_sel_o,
    output lane_init_pkg::trans_sel_e    trans_sel_o,
    output lane_init_pkg::gen_speed_e    gen_speed_o,
    output logic [7:0]                   c_address_o,
    output logic                         c_read_o,
    output logic                         disconnect_sbtx_o,
    output logic                         fsm_disabled_o,
    output logic                         fsm_training_o,
    output logic                         ts1_gen4_s_o,
    output logic                         ts2_gen4_s_o
);
    import lane_init_pkg::*;

    link_state_e state;
    link_state_e next_state;
    logic        usb4_detected;
    logic        train_done;

    link_state_fsm link_state_fsm_i (
        .fsm_clk           (fsm_clk),
        .reset_n           (reset_n),
        .lane_disable_i    (lane_disable_i),
        .tdisabled_min_i   (tdisabled_min_i),
        .disconnect_sbrx_i (disconnect_sbrx_i),
        .t_valid_i         (t_valid_i),
        .trans_error_i     (trans_error_i),
        .trans_sent_i      (trans_sent_i),
        .new_sym_i         (new_sym_i),
        .timers_i          (timers_i),
        .usb4_detected_i   (usb4_detected),
        .gen_speed_i       (gen_speed_o),
        .train_done_i      (train_done),
        .state_o           (state),
        .next_state_o      (next_state),
        .d_sel_o           (d_sel_o),
        .fsm_disabled_o    (fsm_disabled_o),
        .fsm_training_o    (fsm_training_o),
        .ts1_gen4_s_o      (ts1_gen4_s_o),
        .ts2_gen4_s_o      (ts2_gen4_s_o)
    );

    cld_param_collect cld_param_collect_i (
        .fsm_clk         (fsm_clk),
        .reset_n         (reset_n),
        .state_i         (state),
        .next_state_i    (next_state),
        .c_data_i        (c_data_i),
        .payload_i       (payload_i),
        .c_read_o        (c_read_o),
        .c_address_o     (c_address_o),
        .usb4_detected_o (usb4_detected),
        .gen_speed_o     (gen_speed_o)
    );

    os_training_counter os_training_counter_i (
        .fsm_clk      (fsm_clk),
        .reset_n      (reset_n),
        .state_i      (state),
        .next_state_i (next_state),
        .gen_speed_i  (gen_speed_o),
        .os_sent_i    (os_sent_i),
        .lane_os_i    (lane_os_i),
        .train_done_o (train_done)
    );

    sb_transaction_ctrl sb_transaction_ctrl_i (
        .fsm_clk           (fsm_clk),
        .reset_n           (reset_n),
        .state_i           (state),
        .sync_busy_i       (sync_busy_i),
        .trans_error_i     (trans_error_i),
        .trans_sel_o       (trans_sel_o),
        .disconnect_sbtx_o (disconnect_sbtx_o)
    );

endmodule

//--- hdl/sb_transaction_ctrl.sv
module sb_transaction_ctrl (
    input  logic                       fsm_clk,
    input  logic                       reset_n,
    input  lane_init_pkg::link_state_e state_i,
    input  logic                       sync_busy_i,
    input  logic                       trans_error_i,
    output lane_init_pkg::trans_sel_e  trans_sel_o,
    output logic                       disconnect_sbtx_o
);
    import lane_init_pkg::*;

    logic in_exchange;
    logic at_pending;
    logic at_sent;
    logic at_request;

    assign in_exchange = (state_i == CLD_EXCHANGE_1);

    // First request once the exchange starts, another after each error
    assign at_request = in_exchange && !sync_busy_i &&
                        ((at_pending && !at_sent) || trans_error_i);

    always_ff @(posedge fsm_clk or negedge reset_n) begin
        if (!reset_n) begin
            at_pending        <= 1'b0;
            at_sent           <= 1'b0;
            trans_sel_o       <= TR_NONE;
            disconnect_sbtx_o <= 1'b1;
        end else begin
            at_pending        <= in_exchange;
            at_sent           <= in_exchange && (at_sent || trans_sel_o == TR_AT_CMD);
            trans_sel_o       <= at_request ? TR_AT_CMD : TR_NONE;
            // Sideband transmitter stays off until a USB4 cable is found
            disconnect_sbtx_o <= state_i inside {DISABLED, CLD_CABLE};
        end
    end

endmodule

//--- hdl/os_training_counter.sv
`include "lane_init_macros.svh"

module os_training_counter (
    input  logic                       fsm_clk,
    input  logic                       reset_n,
    input  lane_init_pkg::link_state_e state_i,
    input  lane_init_pkg::link_state_e next_state_i,
    input  lane_init_pkg::gen_speed_e  gen_speed_i,
    input  logic                       os_sent_i,
    input  lane_init_pkg::lane_os_t    lane_os_i,
    output logic                       train_done_o
);
    import lane_init_pkg::*;

    logic [`OS_SENT_W-1:0] sent_cnt;
    logic [`OS_SENT_W-1:0] sent_tgt;
    logic [`OS_RCV_W-1:0]  rcv_l0_cnt;
    logic [`OS_RCV_W-1:0]  rcv_l1_cnt;
    logic [`OS_RCV_W-1:0]  rcv_tgt;
    os_sel_e               expect_os;
    logic                  gen2_mode;

    assign expect_os = state_to_os(state_i);
    assign gen2_mode = (gen_speed_i == GEN2);

    always_comb begin
        sent_tgt = '1;
        rcv_tgt  = '1;
        case (state_i)
            TS1_GEN4, TS2_GEN4, TS3_GEN4, TS4_GEN4: begin
                sent_tgt = `OS_SENT_W'(`GEN4_TS_SENT);
                rcv_tgt  = `OS_RCV_W'(`GEN4_TS_RCV);
            end
            SLOS1_GEN3, SLOS2_GEN3: begin
                sent_tgt = `OS_SENT_W'(`SLOS_SENT);
                rcv_tgt  = `OS_RCV_W'(`SLOS_RCV);
            end
            TS1_GEN3: begin
                sent_tgt = gen2_mode ? `OS_SENT_W'(`GEN2_TS1_SENT) : `OS_SENT_W'(`GEN3_TS1_SENT);
                rcv_tgt  = `OS_RCV_W'(`GEN3_TS_RCV);
            end
            TS2_GEN3: begin
                sent_tgt = gen2_mode ? `OS_SENT_W'(`GEN2_TS2_SENT) : `OS_SENT_W'(`GEN3_TS2_SENT);
                rcv_tgt  = `OS_RCV_W'(`GEN3_TS_RCV);
            end
            default: ;
        endcase
    end

    // Counts restart on every state change and saturate at full scale
    always_ff @(posedge fsm_clk or negedge reset_n) begin
        if (!reset_n) begin
            sent_cnt   <= '0;
            rcv_l0_cnt <= '0;
            rcv_l1_cnt <= '0;
        end else if (!is_training(state_i) || next_state_i != state_i) begin
            sent_cnt   <= '0;
            rcv_l0_cnt <= '0;
            rcv_l1_cnt <= '0;
        end else begin
            if (os_sent_i && sent_cnt != '1) begin
                sent_cnt <= sent_cnt + 1'b1;
            end
            if (lane_os_i.l0 == expect_os && rcv_l0_cnt != '1) begin
                rcv_l0_cnt <= rcv_l0_cnt + 1'b1;
            end
            if (lane_os_i.l1 == expect_os && rcv_l1_cnt != '1) begin
                rcv_l1_cnt <= rcv_l1_cnt + 1'b1;
            end
        end
    end

    assign train_done_o = is_training(state_i) && (sent_cnt >= sent_tgt) &&
                          (rcv_l0_cnt >= rcv_tgt) && (rcv_l1_cnt >= rcv_tgt);

endmodule

//--- hdl/cld_param_collect.sv
`include "lane_init_macros.svh"

module cld_param_collect (
    input  logic                       fsm_clk,
    input  logic                       reset_n,
    input  lane_init_pkg::link_state_e state_i,
    input  lane_init_pkg::link_state_e next_state_i,
    input  logic [31:0]                c_data_i,
    input  logic [23:0]                payload_i,
    output logic                       c_read_o,
    output logic [7:0]                 c_address_o,
    output logic                       usb4_detected_o,
    output lane_init_pkg::gen_speed_e  gen_speed_o
);
    import lane_init_pkg::*;

    gen_speed_e cable_gen;
    gen_speed_e partner_gen;
    logic       read_issued;

    // Gen4 bit has priority over the Gen3 bit, neither means Gen2
    function automatic gen_speed_e decode_gen(input logic g4, input logic g3);
        if (g4) begin
            return GEN4;
        end else if (g3) begin
            return GEN3;
        end
        return GEN2;
    endfunction

    assign partner_gen = decode_gen(payload_i[`ADP_GEN4_BIT], payload_i[`ADP_GEN3_BIT]);
    assign c_address_o = (state_i == CLD_CABLE) ? 8'(`CABLE_REG_ADDR) : 8'h00;

    always_ff @(posedge fsm_clk or negedge reset_n) begin
        if (!reset_n) begin
            c_read_o        <= 1'b0;
            read_issued     <= 1'b0;
            usb4_detected_o <= 1'b0;
            cable_gen       <= GEN4;
            gen_speed_o     <= GEN4;
        end else begin
            c_read_o    <= 1'b0;
            read_issued <= 1'b0;
            case (state_i)
                DISABLED: begin
                    usb4_detected_o <= 1'b0;
                    cable_gen       <= GEN4;
                    gen_speed_o     <= GEN4;
                end
                CLD_CABLE: begin
                    // One read strobe per visit, dropped when the state is left
                    read_issued     <= (next_state_i == CLD_CABLE);
                    c_read_o        <= (next_state_i == CLD_CABLE) && !read_issued;
                    usb4_detected_o <= (c_data_i[7:0] == `USB4_CABLE_ID);
                    cable_gen       <= decode_gen(c_data_i[`CABLE_GEN4_BIT],
                                                  c_data_i[`CABLE_GEN3_BIT]);
                    gen_speed_o     <= GEN4;
                end
                CLD_DETECT: gen_speed_o <= GEN4;
                CLD_EXCHANGE_1: begin
                    // Lower generation of cable and partner wins
                    if (cable_gen == GEN2 || partner_gen == GEN2) begin
                        gen_speed_o <= GEN2;
                    end else if (cable_gen == GEN3 || partner_gen == GEN3) begin
                        gen_speed_o <= GEN3;
                    end else begin
                        gen_speed_o <= GEN4;
                    end
                end
                default: ;
            endcase
        end
    end

endmodule

//--- hdl/link_state_fsm.sv
module link_state_fsm (
    input  logic                          fsm_clk,
    input  logic                          reset_n,
    input  logic                          lane_disable_i,
    input  logic                          tdisabled_min_i,
    input  logic                          disconnect_sbrx_i,
    input  logic                          t_valid_i,
    input  logic                          trans_error_i,
    input  logic                          trans_sent_i,
    input  logic                          new_sym_i,
    input  lane_init_pkg::train_timers_t  timers_i,
    input  logic                          usb4_detected_i,
    input  lane_init_pkg::gen_speed_e     gen_speed_i,
    input  logic                          train_done_i,
    output lane_init_pkg::link_state_e    state_o,
    output lane_init_pkg::link_state_e    next_state_o,
    output lane_init_pkg::os_sel_e        d_sel_o,
    output logic                          fsm_disabled_o,
    output logic                          fsm_training_o,
    output logic                          ts1_gen4_s_o,
    output logic                          ts2_gen4_s_o
);
    import lane_init_pkg::*;

    link_state_e state_q;
    link_state_e next_state;
    logic        timeout;
    logic        sb_drop_allowed;
    logic        pre_clock;

    // Timeouts apply to training states only, the Gen4 ones to TS1 and TS2
    assign timeout = is_training(state_q) &&
                     (timers_i.training_error ||
                      (state_q == TS1_GEN4 && timers_i.gen4_ts1) ||
                      (state_q == TS2_GEN4 && timers_i.gen4_ts2));

    assign sb_drop_allowed = is_training(state_q) ||
                             state_q inside {CLD_EXCHANGE_1, CLD_EXCHANGE_2, CL0};

    // States in which the Gen4 training flags are cleared
    assign pre_clock = state_q inside {DISABLED, CLD_CABLE, CLD_DETECT,
                                       CLD_EXCHANGE_1, CLD_EXCHANGE_2};

    always_comb begin
        next_state = state_q;
        case (state_q)
            DISABLED:       if (tdisabled_min_i) next_state = CLD_CABLE;
            CLD_CABLE:      if (usb4_detected_i) next_state = CLD_DETECT;
            CLD_DETECT:     if (!disconnect_sbrx_i) next_state = CLD_EXCHANGE_1;
            CLD_EXCHANGE_1: if (t_valid_i && !trans_error_i) next_state = CLD_EXCHANGE_2;
            CLD_EXCHANGE_2: if (trans_sent_i) next_state = CLD_CLOCK;
            CLD_CLOCK: begin
                if (new_sym_i) begin
                    next_state = (gen_speed_i == GEN4) ? TS1_GEN4 : SLOS1_GEN3;
                end
            end
            TS1_GEN4:       if (train_done_i) next_state = TS2_GEN4;
            TS2_GEN4:       if (train_done_i) next_state = TS3_GEN4;
            TS3_GEN4:       if (train_done_i) next_state = TS4_GEN4;
            TS4_GEN4:       if (train_done_i && new_sym_i) next_state = CL0;
            SLOS1_GEN3:     if (train_done_i) next_state = SLOS2_GEN3;
            SLOS2_GEN3:     if (train_done_i) next_state = TS1_GEN3;
            TS1_GEN3:       if (train_done_i) next_state = TS2_GEN3;
            TS2_GEN3:       if (train_done_i && new_sym_i) next_state = CL0;
            CL0:            next_state = CL0;
            default:        next_state = DISABLED;
        endcase

        // Fallbacks in rising priority
        if (timeout) begin
            next_state = CLD_EXCHANGE_1;
        end
        if (disconnect_sbrx_i && sb_drop_allowed) begin
            next_state = CLD_DETECT;
        end
        if (lane_disable_i) begin
            next_state = DISABLED;
        end
    end

    always_ff @(posedge fsm_clk or negedge reset_n) begin
        if (!reset_n) begin
            state_q        <= DISABLED;
            d_sel_o        <= ZEROS;
            fsm_disabled_o <= 1'b1;
            fsm_training_o <= 1'b0;
            ts1_gen4_s_o   <= 1'b0;
            ts2_gen4_s_o   <= 1'b0;
        end else begin
            state_q <= next_state;
            // Lane data is switched in on the same edge that enters CL0
            if (state_q inside {TS4_GEN4, TS2_GEN3} && next_state == CL0) begin
                d_sel_o <= LANE_DATA;
            end else begin
                d_sel_o <= state_to_os(state_q);
            end
            fsm_disabled_o <= (state_q == DISABLED);
            fsm_training_o <= is_training(state_q);
            ts1_gen4_s_o   <= (state_q == TS1_GEN4) || (ts1_gen4_s_o && !pre_clock);
            ts2_gen4_s_o   <= (state_q == TS2_GEN4) || (ts2_gen4_s_o && !pre_clock);
        end
    end

    assign state_o      = state_q;
    assign next_state_o = next_state;

endmodule

//--- hdl/lane_init_pkg.sv
package lane_init_pkg;

    typedef enum logic [3:0] {
        DISABLED       = 4'd0,
        CLD_CABLE      = 4'd1,
        CLD_DETECT     = 4'd2,
        CLD_EXCHANGE_1 = 4'd3,
        CLD_EXCHANGE_2 = 4'd4,
        CLD_CLOCK      = 4'd5,
        TS1_GEN4       = 4'd6,
        TS2_GEN4       = 4'd7,
        TS3_GEN4       = 4'd8,
        TS4_GEN4       = 4'd9,
        SLOS1_GEN3     = 4'd10,
        SLOS2_GEN3     = 4'd11,
        TS1_GEN3       = 4'd12,
        TS2_GEN3       = 4'd13,
        CL0            = 4'd14
    } link_state_e;

    typedef enum logic [1:0] {
        GEN4 = 2'd0,
        GEN3 = 2'd1,
        GEN2 = 2'd2
    } gen_speed_e;

    // Lane-data select, also the code of an ordered set seen on a lane
    typedef enum logic [3:0] {
        SLOS1     = 4'd0,
        SLOS2     = 4'd1,
        TS1_G3    = 4'd2,
        TS2_G3    = 4'd3,
        TS1_G4    = 4'd4,
        TS2_G4    = 4'd5,
        TS3_G4    = 4'd6,
        TS4_G4    = 4'd7,
        LANE_DATA = 4'd8,
        ZEROS     = 4'd9
    } os_sel_e;

    typedef enum logic [1:0] {
        TR_NONE   = 2'd0,
        TR_AT_CMD = 2'd2
    } trans_sel_e;

    typedef struct packed {
        os_sel_e l0;
        os_sel_e l1;
    } lane_os_t;

    typedef struct packed {
        logic training_error;
        logic gen4_ts1;
        logic gen4_ts2;
    } train_timers_t;

    function automatic logic is_training(input link_state_e s);
        return s inside {TS1_GEN4, TS2_GEN4, TS3_GEN4, TS4_GEN4,
                         SLOS1_GEN3, SLOS2_GEN3, TS1_GEN3, TS2_GEN3};
    endfunction

    // Ordered set transmitted, and expected back, in each state
    function automatic os_sel_e state_to_os(input link_state_e s);
        case (s)
            TS1_GEN4:   return TS1_G4;
            TS2_GEN4:   return TS2_G4;
            TS3_GEN4:   return TS3_G4;
            TS4_GEN4:   return TS4_G4;
            SLOS1_GEN3: return SLOS1;
            SLOS2_GEN3: return SLOS2;
            TS1_GEN3:   return TS1_G3;
            TS2_GEN3:   return TS2_G3;
            CL0:        return LANE_DATA;
            default:    return ZEROS;
        endcase
    endfunction

endpackage

//--- hdl/lane_init_macros.svh
`ifndef LANE_INIT_MACROS_SVH
`define LANE_INIT_MACROS_SVH

// Ordered-set counter widths
`define OS_SENT_W 6
`define OS_RCV_W 4

// Gen4 targets, the same for each of TS1 to TS4
`define GEN4_TS_SENT 16
`define GEN4_TS_RCV 1

// SLOS1 and SLOS2 targets at Gen3 and Gen2
`define SLOS_SENT 2
`define SLOS_RCV 2

// TS1 and TS2 targets, Gen2 runs the longer sequences
`define GEN3_TS1_SENT 16
`define GEN2_TS1_SENT 32
`define GEN3_TS2_SENT 8
`define GEN2_TS2_SENT 16
`define GEN3_TS_RCV 2

// Cable configuration register
`define CABLE_REG_ADDR 18
`define USB4_CABLE_ID 8'h40

// Generation bits in the cable word and in the exchange payload
`define CABLE_GEN4_BIT 21
`define CABLE_GEN3_BIT 20
`define ADP_GEN4_BIT 18
`define ADP_GEN3_BIT 13

`endif
